/* common/nor_seq_pkg.sv */
// NOR command sequencer definitions

package nor_seq_pkg;

    // bus and field widths
    localparam int NOR_CMD_W     = 6;
    localparam int NOR_ADDR_W    = 26;
    localparam int NOR_DATA_W    = 16;
    // unlock addresses from the table are short, zero-extended on the bus
    localparam int NOR_UNLOCK_W  = 12;
    // longest command is the six-cycle erase
    localparam int NOR_MAX_STEPS = 6;

    // command code as carried in the top bits of the host address
    typedef logic [NOR_CMD_W-1:0] nor_cmd_t;

    // flash word address
    typedef logic [NOR_ADDR_W-1:0] nor_addr_t;

    // flash data word
    typedef logic [NOR_DATA_W-1:0] nor_data_t;

    // address field of a table entry
    typedef logic [NOR_UNLOCK_W-1:0] nor_unlock_addr_t;

    // step index and step count, wide enough for NOR_MAX_STEPS
    typedef logic [2:0] nor_step_t;

    // command codes
    // read is the only one that runs with we low
    localparam nor_cmd_t CMD_READ         = 6'd0;
    localparam nor_cmd_t CMD_CFI_ENTER    = 6'd1;
    localparam nor_cmd_t CMD_PROGRAM      = 6'd2;
    localparam nor_cmd_t CMD_ERASE_SECTOR = 6'd3;
    localparam nor_cmd_t CMD_ERASE_CHIP   = 6'd4;
    // any code not listed here is handled as reset
    localparam nor_cmd_t CMD_RESET        = 6'd5;
    localparam nor_cmd_t CMD_WRITE_BUF    = 6'd6;
    localparam nor_cmd_t CMD_PROG_BUF     = 6'd7;
    localparam nor_cmd_t CMD_WRITE        = 6'd8;

    // one host request, 48 bits
    // cmd and addr come from the host address word, data from the data word
    typedef struct packed {
        nor_cmd_t  cmd;
        nor_addr_t addr;
        nor_data_t data;
    } nor_req_t;

    // one flash bus cycle, 43 bits
    // data is don't care when we is low
    typedef struct packed {
        nor_addr_t addr;
        nor_data_t data;
        logic      we;
    } nor_bus_cycle_t;

endpackage

/* dv/nor_ctrl_checker.sv */
// NOR controller bus checker

`timescale 1ns/10ps

module nor_ctrl_checker (
    input  logic                   wb_clk_i,
    input  logic                   mod_reset,

    // host port as seen by the DUT
    input  logic                   wbs_cyc_i,
    input  logic                   wbs_stb_i,
    input  logic [31:0]            wbs_adr_i,
    input  nor_seq_pkg::nor_data_t wbs_dat_i,
    input  logic                   wbs_stall_o,
    input  logic                   wbs_ack_o,
    input  nor_seq_pkg::nor_data_t wbs_dat_o,

    // flash port
    input  nor_seq_pkg::nor_addr_t wbm_adr_o,
    input  nor_seq_pkg::nor_data_t wbm_dat_o,
    input  logic                   wbm_we_o,
    input  logic                   wbm_stb_o,
    input  logic                   wbm_cyc_o,
    input  logic                   wbm_ack_i,
    input  logic                   wbm_stall_i,

    // end of stimulus, run the closing checks
    input  logic                   final_check_i,
    output int                     error_count_o,
    output int                     ack_count_o
);

    import nor_seq_pkg::*;

    // accepted requests not yet acked, oldest first
    nor_req_t       req_q[$];
    // flash acks still owed per outstanding request
    int             left_q[$];
    // flat list of expected flash cycles
    nor_bus_cycle_t exp_q[$];

    int        errors          = 0;
    int        acks            = 0;
    logic      overlap_seen    = 1'b0;
    logic      full_stall_seen = 1'b0;
    logic      final_done      = 1'b0;

    // previous sample, for the stall hold check
    logic      prev_hold       = 1'b0;
    nor_addr_t prev_adr;
    nor_data_t prev_dat;
    logic      prev_we;

    assign error_count_o = errors;
    assign ack_count_o   = acks;

    task automatic report_mismatch(input string test, input logic [31:0] exp_val,
                                   input logic [31:0] act_val);
        $display("[FAIL] %s: expected %h, actual %h at %0t", test, exp_val, act_val, $time);
        errors++;
    endtask

    task automatic protocol_error(input string msg);
        $display("ERROR: %s at %0t", msg, $time);
        errors++;
    endtask

    task automatic add_step(input nor_addr_t a, input nor_data_t d, input logic we);
        nor_bus_cycle_t c;
        c.addr = a;
        c.data = d;
        c.we   = we;
        exp_q.push_back(c);
    endtask

    // 555/AA then 2AA/55
    task automatic add_unlock_pair();
        add_step(26'h555, 16'h00AA, 1'b1);
        add_step(26'h2AA, 16'h0055, 1'b1);
    endtask

    // step rule of the reference, one entry per flash cycle
    task automatic expand_request(input nor_req_t r);
        int n;
        n = exp_q.size();
        case (r.cmd)
            CMD_READ: begin
                add_step(r.addr, 16'h0000, 1'b0);
            end
            CMD_CFI_ENTER: begin
                add_step(26'h055, 16'h0098, 1'b1);
            end
            CMD_PROGRAM: begin
                add_unlock_pair();
                add_step(26'h555, 16'h00A0, 1'b1);
                add_step(r.addr, r.data, 1'b1);
            end
            CMD_ERASE_SECTOR, CMD_ERASE_CHIP: begin
                add_unlock_pair();
                add_step(26'h555, 16'h0080, 1'b1);
                add_unlock_pair();
                if (r.cmd == CMD_ERASE_SECTOR) begin
                    add_step(r.addr, 16'h0030, 1'b1);
                end else begin
                    add_step(26'h555, 16'h0010, 1'b1);
                end
            end
            CMD_WRITE_BUF: begin
                add_unlock_pair();
                add_step(r.addr, 16'h0025, 1'b1);
                add_step(r.addr, r.data, 1'b1);
            end
            CMD_PROG_BUF: begin
                add_step(r.addr, 16'h0029, 1'b1);
            end
            CMD_WRITE: begin
                add_step(r.addr, r.data, 1'b1);
            end
            // reset and every unknown code
            default: begin
                add_step(26'h000, 16'h00F0, 1'b1);
            end
        endcase
        left_q.push_back(exp_q.size() - n);
    endtask

    // sample mid cycle, inputs and outputs both settled
    always @(negedge wb_clk_i) begin : sample
        nor_bus_cycle_t e;
        nor_req_t       r;
        int             left;
        if (mod_reset) begin
            if (wbs_ack_o || wbs_stall_o || wbm_cyc_o || wbm_stb_o) begin
                protocol_error("DUT outputs not low during reset");
            end
            prev_hold = 1'b0;
        end else begin
            // flash bus protocol
            if (wbm_stb_o && !wbm_cyc_o) begin
                protocol_error("wbm_stb_o high without wbm_cyc_o");
            end
            if (prev_hold) begin
                if (!wbm_stb_o) begin
                    protocol_error("wbm_stb_o dropped while the flash stalled");
                end else if (wbm_adr_o != prev_adr || wbm_dat_o != prev_dat
                             || wbm_we_o != prev_we) begin
                    protocol_error("flash cycle fields changed while stalled");
                end
            end
            prev_hold = wbm_stb_o && wbm_stall_i;
            prev_adr  = wbm_adr_o;
            prev_dat  = wbm_dat_o;
            prev_we   = wbm_we_o;

            // flash cycle accepted, compare with the next expected step
            if (wbm_stb_o && !wbm_stall_i) begin
                if (exp_q.size() == 0) begin
                    protocol_error("flash cycle issued with no expected step");
                end else begin
                    e = exp_q.pop_front();
                    if (wbm_adr_o != e.addr) begin
                        report_mismatch("flash cycle address", 32'(e.addr), 32'(wbm_adr_o));
                    end
                    if (wbm_we_o != e.we) begin
                        report_mismatch("flash cycle we", 32'(e.we), 32'(wbm_we_o));
                    end
                    // read data field is don't care
                    if (e.we && wbm_dat_o != e.data) begin
                        report_mismatch("flash cycle data", 32'(e.data), 32'(wbm_dat_o));
                    end
                end
            end

            // flash ack counts against the oldest request
            if (wbm_cyc_o && wbm_ack_i) begin
                if (left_q.size() == 0 || left_q[0] == 0) begin
                    protocol_error("flash ack with no flash cycle owed");
                end else begin
                    left_q[0] = left_q[0] - 1;
                end
            end

            // host ack, in order, after all flash cycles
            if (wbs_ack_o) begin
                acks++;
                if (req_q.size() == 0) begin
                    protocol_error("wbs_ack_o with no outstanding request");
                end else begin
                    r    = req_q.pop_front();
                    left = left_q.pop_front();
                    if (left != 0) begin
                        protocol_error("host ack before all flash cycles were acked");
                    end
                    if (r.cmd == CMD_READ && wbs_dat_o != (r.addr[15:0] ^ 16'h5A5A)) begin
                        report_mismatch("read data", 32'(r.addr[15:0] ^ 16'h5A5A),
                                        32'(wbs_dat_o));
                    end
                end
            end

            // host request accepted
            if (wbs_cyc_i && wbs_stb_i && !wbs_stall_o) begin
                // second request while the first is still in flight
                if (req_q.size() > 0) begin
                    overlap_seen = 1'b1;
                end
                r.cmd  = wbs_adr_i[31:26];
                r.addr = wbs_adr_i[25:0];
                r.data = wbs_dat_i;
                req_q.push_back(r);
                expand_request(r);
            end
            if (wbs_cyc_i && wbs_stb_i && wbs_stall_o) begin
                full_stall_seen = 1'b1;
            end
        end

        if (final_check_i && !final_done) begin
            final_done = 1'b1;
            if (req_q.size() != 0) begin
                protocol_error("requests left without a host ack");
            end
            if (exp_q.size() != 0) begin
                protocol_error("expected flash cycles never issued");
            end
            if (!overlap_seen) begin
                protocol_error("no request accepted while another was in flight");
            end
            if (!full_stall_seen) begin
                protocol_error("wbs_stall_o never seen with a request waiting");
            end
        end
    end

endmodule

/* dv/tb_nor_flash_ctrl.sv */
// NOR flash controller testbench

`timescale 1ns/10ps

module tb_nor_flash_ctrl;

    import nor_seq_pkg::*;

    localparam int NUM_REQ      = 400;
    localparam int SEED         = 43635;
    // worst case six steps of about twelve cycles each
    localparam int WATCHDOG_CYC = NUM_REQ * NOR_MAX_STEPS * 12 + 1000;

    logic        wb_clk_i;
    logic        mod_reset;
    logic        wbs_cyc_i;
    logic        wbs_stb_i;
    logic        wbs_we_i;
    logic [31:0] wbs_adr_i;
    nor_data_t   wbs_dat_i;
    logic        wbs_stall_o;
    logic        wbs_ack_o;
    nor_data_t   wbs_dat_o;
    nor_addr_t   wbm_adr_o;
    nor_data_t   wbm_dat_o;
    logic        wbm_we_o;
    logic        wbm_stb_o;
    logic        wbm_cyc_o;
    logic        wbm_ack_i;
    nor_data_t   wbm_dat_i;
    logic        wbm_stall_i;

    logic        final_check;
    int          error_count;
    int          ack_count;

    nor_flash_ctrl DUT (
        .wb_clk_i    (wb_clk_i),
        .mod_reset   (mod_reset),
        .wbs_cyc_i   (wbs_cyc_i),
        .wbs_stb_i   (wbs_stb_i),
        .wbs_we_i    (wbs_we_i),
        .wbs_adr_i   (wbs_adr_i),
        .wbs_dat_i   (wbs_dat_i),
        .wbs_stall_o (wbs_stall_o),
        .wbs_ack_o   (wbs_ack_o),
        .wbs_dat_o   (wbs_dat_o),
        .wbm_adr_o   (wbm_adr_o),
        .wbm_dat_o   (wbm_dat_o),
        .wbm_we_o    (wbm_we_o),
        .wbm_stb_o   (wbm_stb_o),
        .wbm_cyc_o   (wbm_cyc_o),
        .wbm_ack_i   (wbm_ack_i),
        .wbm_dat_i   (wbm_dat_i),
        .wbm_stall_i (wbm_stall_i)
    );

    nor_ctrl_checker u_checker (
        .wb_clk_i      (wb_clk_i),
        .mod_reset     (mod_reset),
        .wbs_cyc_i     (wbs_cyc_i),
        .wbs_stb_i     (wbs_stb_i),
        .wbs_adr_i     (wbs_adr_i),
        .wbs_dat_i     (wbs_dat_i),
        .wbs_stall_o   (wbs_stall_o),
        .wbs_ack_o     (wbs_ack_o),
        .wbs_dat_o     (wbs_dat_o),
        .wbm_adr_o     (wbm_adr_o),
        .wbm_dat_o     (wbm_dat_o),
        .wbm_we_o      (wbm_we_o),
        .wbm_stb_o     (wbm_stb_o),
        .wbm_cyc_o     (wbm_cyc_o),
        .wbm_ack_i     (wbm_ack_i),
        .wbm_stall_i   (wbm_stall_i),
        .final_check_i (final_check),
        .error_count_o (error_count),
        .ack_count_o   (ack_count)
    );

    initial begin
        wb_clk_i = 1'b0;
        forever #5 wb_clk_i = ~wb_clk_i;
    end

    // one random request held until the DUT takes it
    task automatic send_request();
        int       idle;
        logic     taken;
        nor_cmd_t cmd;
        idle = $urandom_range(0, 3);
        cmd  = nor_cmd_t'($urandom_range(0, 15));
        if (idle > 0) begin
            wbs_cyc_i = 1'b0;
            wbs_stb_i = 1'b0;
            repeat (idle) begin
                @(posedge wb_clk_i);
                #1;
            end
        end
        wbs_cyc_i = 1'b1;
        wbs_stb_i = 1'b1;
        wbs_we_i  = (cmd != CMD_READ);
        wbs_adr_i = {cmd, nor_addr_t'($urandom())};
        wbs_dat_i = nor_data_t'($urandom());
        taken     = 1'b0;
        while (!taken) begin
            // stall comes from a flop and is steady from mid cycle to the edge
            @(negedge wb_clk_i);
            taken = !wbs_stall_o;
            @(posedge wb_clk_i);
            #1;
        end
    endtask

    // ack with the read word and go back to random data
    task automatic return_ack();
        wbm_ack_i = 1'b1;
        wbm_dat_i = wbm_adr_o[15:0] ^ 16'h5A5A;
        @(posedge wb_clk_i);
        #1;
        wbm_ack_i = 1'b0;
        wbm_dat_i = nor_data_t'($urandom());
    endtask

    // flash model with random stall and ack delay per cycle
    initial begin : flash_responder
        int stall_n;
        int ack_d;
        wait (mod_reset === 1'b0);
        forever begin
            @(posedge wb_clk_i);
            #1;
            if (wbm_stb_o) begin
                stall_n     = $urandom_range(0, 3);
                ack_d       = $urandom_range(0, 4);
                wbm_stall_i = (stall_n != 0);
                repeat (stall_n) begin
                    @(posedge wb_clk_i);
                    #1;
                end
                wbm_stall_i = 1'b0;
                if (ack_d == 0) begin
                    // ack on the accepting edge
                    return_ack();
                end else begin
                    @(posedge wb_clk_i);
                    #1;
                    repeat (ack_d - 1) begin
                        @(posedge wb_clk_i);
                        #1;
                    end
                    return_ack();
                end
            end
        end
    end

    initial begin : stimulus
        void'($urandom(SEED));
        mod_reset   = 1'b1;
        wbs_cyc_i   = 1'b0;
        wbs_stb_i   = 1'b0;
        wbs_we_i    = 1'b0;
        wbs_adr_i   = '0;
        wbs_dat_i   = '0;
        wbm_ack_i   = 1'b0;
        wbm_dat_i   = '0;
        wbm_stall_i = 1'b0;
        final_check = 1'b0;
        repeat (2) @(posedge wb_clk_i);
        #1;
        mod_reset = 1'b0;

        for (int i = 0; i < NUM_REQ; i++) begin
            send_request();
        end
        wbs_cyc_i = 1'b0;
        wbs_stb_i = 1'b0;

        // wait for the remaining host acks
        while (ack_count < NUM_REQ) begin
            @(posedge wb_clk_i);
        end
        #1;
        final_check = 1'b1;
        repeat (2) @(posedge wb_clk_i);

        $display("requests %0d, host acks %0d, errors %0d", NUM_REQ, ack_count, error_count);
        if (error_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYC) @(posedge wb_clk_i);
        $display("watchdog expired after %0d cycles, not all requests were acked",
                 WATCHDOG_CYC);
        $display("Test FAILED");
        $finish;
    end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# compile and run the NOR flash controller testbench with Verilator
set -e
cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module tb_nor_flash_ctrl \
    -Mdir "$BUILD_DIR" -o sim_nor_flash_ctrl \
    -f sources.f

"./$BUILD_DIR/sim_nor_flash_ctrl" > "$LOG" 2>&1 || true
cat "$LOG"

if grep -qx "Test OK" "$LOG"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation did not pass, see $LOG"
    exit 1
fi

/* sequencer/nor_cmd_table.sv */
// NOR command step table

`timescale 1ns/10ps

module nor_cmd_table (
    input  nor_seq_pkg::nor_cmd_t         cmd_i,
    input  nor_seq_pkg::nor_step_t        step_i,
    output nor_seq_pkg::nor_step_t        step_count_o,
    output nor_seq_pkg::nor_unlock_addr_t tbl_addr_o,
    output nor_seq_pkg::nor_data_t        tbl_data_o,
    // 1 = take the supplied address or data instead of the table value
    output logic                          use_addr_o,
    output logic                          use_data_o
);

    import nor_seq_pkg::*;

    always_comb begin
        // defaults give the single reset cycle 000/F0
        step_count_o = 3'd1;
        tbl_addr_o   = 12'h000;
        tbl_data_o   = 16'h00F0;
        use_addr_o   = 1'b0;
        use_data_o   = 1'b0;

        case (cmd_i)
            CMD_READ: begin
                // data field unused, the flash drives it
                use_addr_o = 1'b1;
                tbl_data_o = 16'h0000;
            end
            CMD_CFI_ENTER: begin
                tbl_addr_o = 12'h055;
                tbl_data_o = 16'h0098;
            end
            CMD_PROGRAM, CMD_WRITE_BUF: begin
                step_count_o = 3'd4;
                case (step_i)
                    // unlock pair
                    3'd0: begin
                        tbl_addr_o = 12'h555;
                        tbl_data_o = 16'h00AA;
                    end
                    3'd1: begin
                        tbl_addr_o = 12'h2AA;
                        tbl_data_o = 16'h0055;
                    end
                    // program setup, or buffer load at the sector address
                    3'd2: begin
                        if (cmd_i == CMD_PROGRAM) begin
                            tbl_addr_o = 12'h555;
                            tbl_data_o = 16'h00A0;
                        end else begin
                            use_addr_o = 1'b1;
                            tbl_data_o = 16'h0025;
                        end
                    end
                    // final word at the supplied location
                    default: begin
                        use_addr_o = 1'b1;
                        use_data_o = 1'b1;
                    end
                endcase
            end
            CMD_ERASE_SECTOR, CMD_ERASE_CHIP: begin
                step_count_o = 3'd6;
                case (step_i)
                    3'd0, 3'd3: begin
                        tbl_addr_o = 12'h555;
                        tbl_data_o = 16'h00AA;
                    end
                    3'd1, 3'd4: begin
                        tbl_addr_o = 12'h2AA;
                        tbl_data_o = 16'h0055;
                    end
                    3'd2: begin
                        tbl_addr_o = 12'h555;
                        tbl_data_o = 16'h0080;
                    end
                    // sector erase goes to the supplied sector
                    default: begin
                        if (cmd_i == CMD_ERASE_SECTOR) begin
                            use_addr_o = 1'b1;
                            tbl_data_o = 16'h0030;
                        end else begin
                            tbl_addr_o = 12'h555;
                            tbl_data_o = 16'h0010;
                        end
                    end
                endcase
            end
            CMD_PROG_BUF: begin
                use_addr_o = 1'b1;
                tbl_data_o = 16'h0029;
            end
            CMD_WRITE: begin
                use_addr_o = 1'b1;
                use_data_o = 1'b1;
            end
            // CMD_RESET and unknown codes keep the defaults
            default: begin
                step_count_o = 3'd1;
            end
        endcase
    end

endmodule

/* sequencer/nor_cycle_sequencer.sv */
// NOR bus cycle sequencer

`timescale 1ns/10ps

module nor_cycle_sequencer (
    input  logic                        wb_clk_i,
    input  logic                        mod_reset,

    // pending request from the intake
    input  logic                        pend_valid_i,
    input  nor_seq_pkg::nor_req_t       pend_req_i,
    output logic                        pend_take_o,

    // one bus cycle at a time to the master
    output logic                        cyc_valid_o,
    output nor_seq_pkg::nor_bus_cycle_t cyc_data_o,
    input  logic                        cyc_ready_i,
    input  logic                        cyc_done_i,
    input  nor_seq_pkg::nor_data_t      cyc_rdata_i,

    // host response
    output logic                        wbs_ack_o,
    output nor_seq_pkg::nor_data_t      wbs_dat_o
);

    import nor_seq_pkg::*;

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_ISSUE,
        SEQ_WAIT
    } seq_state_t;

    seq_state_t       state;
    nor_req_t         cur_req;
    nor_step_t        step;
    nor_step_t        step_count;
    nor_unlock_addr_t tbl_addr;
    nor_data_t        tbl_data;
    logic             use_addr;
    logic             use_data;
    logic             last_step;
    logic             is_read;

    nor_cmd_table u_cmd_table (
        .cmd_i        (cur_req.cmd),
        .step_i       (step),
        .step_count_o (step_count),
        .tbl_addr_o   (tbl_addr),
        .tbl_data_o   (tbl_data),
        .use_addr_o   (use_addr),
        .use_data_o   (use_data)
    );

    // take straight from idle without an extra cycle
    assign pend_take_o = (state == SEQ_IDLE) && pend_valid_i;
    assign cyc_valid_o = (state == SEQ_ISSUE);
    assign is_read     = (cur_req.cmd == CMD_READ);
    assign last_step   = (step == step_count - 3'd1);

    // merge table entry with the supplied fields
    always_comb begin
        cyc_data_o.addr = use_addr ? cur_req.addr : nor_addr_t'(tbl_addr);
        cyc_data_o.data = use_data ? cur_req.data : tbl_data;
        cyc_data_o.we   = !is_read;
    end

    always_ff @(posedge wb_clk_i) begin
        if (mod_reset) begin
            state     <= SEQ_IDLE;
            step      <= '0;
            wbs_ack_o <= 1'b0;
        end else begin
            // ack is a single pulse
            wbs_ack_o <= 1'b0;
            case (state)
                SEQ_IDLE: begin
                    if (pend_valid_i) begin
                        step  <= '0;
                        state <= SEQ_ISSUE;
                    end
                end
                // wait for the master to take the cycle
                SEQ_ISSUE: begin
                    if (cyc_ready_i) begin
                        state <= SEQ_WAIT;
                    end
                end
                SEQ_WAIT: begin
                    if (cyc_done_i) begin
                        if (last_step) begin
                            wbs_ack_o <= 1'b1;
                            state     <= SEQ_IDLE;
                        end else begin
                            step  <= step + 3'd1;
                            state <= SEQ_ISSUE;
                        end
                    end
                end
                default: begin
                    state <= SEQ_IDLE;
                end
            endcase
        end
    end

    // latched request and the read word that goes out with the ack
    always_ff @(posedge wb_clk_i) begin
        if (pend_take_o) begin
            cur_req <= pend_req_i;
        end
        if (state == SEQ_WAIT && cyc_done_i && is_read) begin
            wbs_dat_o <= cyc_rdata_i;
        end
    end

    // step index inside the command's table range
    assert property (@(posedge wb_clk_i) disable iff (mod_reset)
        state != SEQ_IDLE |-> step < step_count);

    // offered cycle held steady until the master accepts it
    assert property (@(posedge wb_clk_i) disable iff (mod_reset)
        cyc_valid_o && !cyc_ready_i |=> cyc_valid_o && $stable(cyc_data_o));

endmodule

/* sources.f */
common/nor_seq_pkg.sv
src/nor_req_intake.sv
sequencer/nor_cmd_table.sv
sequencer/nor_cycle_sequencer.sv
src/nor_bus_master.sv
src/nor_flash_ctrl.sv
dv/nor_ctrl_checker.sv
dv/tb_nor_flash_ctrl.sv

/* src/nor_bus_master.sv */
// Flash side bus master

`timescale 1ns/10ps

module nor_bus_master (
    input  logic                        wb_clk_i,
    input  logic                        mod_reset,

    // cycle handover from the sequencer
    input  logic                        cyc_valid_i,
    input  nor_seq_pkg::nor_bus_cycle_t cyc_data_i,
    output logic                        cyc_ready_o,
    output logic                        cyc_done_o,
    output nor_seq_pkg::nor_data_t      cyc_rdata_o,

    // flash side, pipelined wishbone master
    output nor_seq_pkg::nor_addr_t      wbm_adr_o,
    output nor_seq_pkg::nor_data_t      wbm_dat_o,
    output logic                        wbm_we_o,
    output logic                        wbm_stb_o,
    output logic                        wbm_cyc_o,
    input  logic                        wbm_ack_i,
    input  nor_seq_pkg::nor_data_t      wbm_dat_i,
    input  logic                        wbm_stall_i
);

    typedef enum logic [1:0] {
        M_IDLE,
        M_REQ,
        M_ACK
    } master_state_t;

    master_state_t state;
    logic          finish;

    // idle means ready for the next cycle
    assign cyc_ready_o = (state == M_IDLE);
    // stb only in the request phase, cyc until ack
    assign wbm_stb_o   = (state == M_REQ);
    assign wbm_cyc_o   = (state != M_IDLE);

    // ack may come in the same cycle the request is accepted
    assign finish = wbm_ack_i && (state == M_ACK || (state == M_REQ && !wbm_stall_i));

    always_ff @(posedge wb_clk_i) begin
        if (mod_reset) begin
            state      <= M_IDLE;
            wbm_we_o   <= 1'b0;
            cyc_done_o <= 1'b0;
        end else begin
            cyc_done_o <= 1'b0;
            case (state)
                M_IDLE: begin
                    if (cyc_valid_i) begin
                        wbm_we_o <= cyc_data_i.we;
                        state    <= M_REQ;
                    end
                end
                // hold everything while the flash stalls
                M_REQ: begin
                    if (!wbm_stall_i) begin
                        state <= M_ACK;
                    end
                end
                default: begin
                    state <= state;
                end
            endcase
            // done pulse on the edge after ack
            if (finish) begin
                wbm_we_o   <= 1'b0;
                cyc_done_o <= 1'b1;
                state      <= M_IDLE;
            end
        end
    end

    // address and data loaded once per handover
    always_ff @(posedge wb_clk_i) begin
        if (cyc_ready_o && cyc_valid_i) begin
            wbm_adr_o <= cyc_data_i.addr;
            wbm_dat_o <= cyc_data_i.data;
        end
        if (finish) begin
            cyc_rdata_o <= wbm_dat_i;
        end
    end

    // stalled request keeps its address, data and direction
    assert property (@(posedge wb_clk_i) disable iff (mod_reset)
        wbm_stb_o && wbm_stall_i |=> wbm_stb_o && $stable(wbm_adr_o)
            && $stable(wbm_dat_o) && $stable(wbm_we_o));

endmodule

/* src/nor_flash_ctrl.sv */
// NOR flash controller top

`timescale 1ns/10ps

module nor_flash_ctrl (
    input  logic                   wb_clk_i,
    input  logic                   mod_reset,

    // host port
    input  logic                   wbs_cyc_i,
    input  logic                   wbs_stb_i,
    // direction follows the command code, we is not looked at
    input  logic                   wbs_we_i,
    input  logic [nor_seq_pkg::NOR_CMD_W+nor_seq_pkg::NOR_ADDR_W-1:0] wbs_adr_i,
    input  nor_seq_pkg::nor_data_t wbs_dat_i,
    output logic                   wbs_stall_o,
    output logic                   wbs_ack_o,
    output nor_seq_pkg::nor_data_t wbs_dat_o,

    // flash port
    output nor_seq_pkg::nor_addr_t wbm_adr_o,
    output nor_seq_pkg::nor_data_t wbm_dat_o,
    output logic                   wbm_we_o,
    output logic                   wbm_stb_o,
    output logic                   wbm_cyc_o,
    input  logic                   wbm_ack_i,
    input  nor_seq_pkg::nor_data_t wbm_dat_i,
    input  logic                   wbm_stall_i
);

    import nor_seq_pkg::*;

    // intake to sequencer
    logic           pend_valid;
    logic           pend_take;
    nor_req_t       pend_req;

    // sequencer to master
    logic           cyc_valid;
    logic           cyc_ready;
    logic           cyc_done;
    nor_bus_cycle_t cyc_data;
    nor_data_t      cyc_rdata;

    nor_req_intake u_intake (
        .wb_clk_i     (wb_clk_i),
        .mod_reset    (mod_reset),
        .wbs_cyc_i    (wbs_cyc_i),
        .wbs_stb_i    (wbs_stb_i),
        .wbs_adr_i    (wbs_adr_i),
        .wbs_dat_i    (wbs_dat_i),
        .wbs_stall_o  (wbs_stall_o),
        .pend_take_i  (pend_take),
        .pend_valid_o (pend_valid),
        .pend_req_o   (pend_req)
    );

    nor_cycle_sequencer u_sequencer (
        .wb_clk_i     (wb_clk_i),
        .mod_reset    (mod_reset),
        .pend_valid_i (pend_valid),
        .pend_req_i   (pend_req),
        .pend_take_o  (pend_take),
        .cyc_valid_o  (cyc_valid),
        .cyc_data_o   (cyc_data),
        .cyc_ready_i  (cyc_ready),
        .cyc_done_i   (cyc_done),
        .cyc_rdata_i  (cyc_rdata),
        .wbs_ack_o    (wbs_ack_o),
        .wbs_dat_o    (wbs_dat_o)
    );

    nor_bus_master u_master (
        .wb_clk_i     (wb_clk_i),
        .mod_reset    (mod_reset),
        .cyc_valid_i  (cyc_valid),
        .cyc_data_i   (cyc_data),
        .cyc_ready_o  (cyc_ready),
        .cyc_done_o   (cyc_done),
        .cyc_rdata_o  (cyc_rdata),
        .wbm_adr_o    (wbm_adr_o),
        .wbm_dat_o    (wbm_dat_o),
        .wbm_we_o     (wbm_we_o),
        .wbm_stb_o    (wbm_stb_o),
        .wbm_cyc_o    (wbm_cyc_o),
        .wbm_ack_i    (wbm_ack_i),
        .wbm_dat_i    (wbm_dat_i),
        .wbm_stall_i  (wbm_stall_i)
    );

endmodule

/* src/nor_req_intake.sv */
// Host request intake

`timescale 1ns/10ps

module nor_req_intake (
    input  logic                   wb_clk_i,
    input  logic                   mod_reset,

    // host side, pipelined wishbone slave
    input  logic                   wbs_cyc_i,
    input  logic                   wbs_stb_i,
    input  logic [nor_seq_pkg::NOR_CMD_W+nor_seq_pkg::NOR_ADDR_W-1:0] wbs_adr_i,
    input  nor_seq_pkg::nor_data_t wbs_dat_i,
    output logic                   wbs_stall_o,

    // pending request towards the sequencer
    input  logic                   pend_take_i,
    output logic                   pend_valid_o,
    output nor_seq_pkg::nor_req_t  pend_req_o
);

    import nor_seq_pkg::*;

    // holding register state
    logic     full;
    logic     accept;
    nor_req_t host_req;

    // split the host address word into command and flash address
    assign host_req.cmd  = wbs_adr_i[NOR_ADDR_W +: NOR_CMD_W];
    assign host_req.addr = wbs_adr_i[NOR_ADDR_W-1:0];
    assign host_req.data = wbs_dat_i;

    // handshake on cyc, stb and no stall
    assign accept = wbs_cyc_i && wbs_stb_i && !wbs_stall_o;

    // stall while the entry is still waiting for the sequencer
    assign wbs_stall_o  = full;
    assign pend_valid_o = full;

    // full flag
    always_ff @(posedge wb_clk_i) begin
        if (mod_reset) begin
            full <= 1'b0;
        end else if (accept) begin
            full <= 1'b1;
        end else if (pend_take_i) begin
            full <= 1'b0;
        end
    end

    // payload only loads on a handshake
    always_ff @(posedge wb_clk_i) begin
        if (accept) begin
            pend_req_o <= host_req;
        end
    end

    // entry held unchanged until the sequencer takes it
    assert property (@(posedge wb_clk_i) disable iff (mod_reset)
        pend_valid_o && !pend_take_i |=> pend_valid_o && $stable(pend_req_o));

    // sequencer never takes from an empty holding register
    assert property (@(posedge wb_clk_i) disable iff (mod_reset)
        pend_take_i |-> pend_valid_o);

endmodule
